// ==== exu_params.svh ====
// widths, ALU op codes and result-select codes for the execute stage, included by package and RTL
`ifndef EXU_PARAMS_SVH
`define EXU_PARAMS_SVH

// data path and register file
`define XLEN        32
`define REG_AW      5

// alu op codes
`define ALU_OP_W    4
`define ALU_ADD     4'd0
`define ALU_SUB     4'd1
`define ALU_AND     4'd2
`define ALU_OR      4'd3
`define ALU_XOR     4'd4
`define ALU_SLL     4'd5
`define ALU_SRL     4'd6
`define ALU_SRA     4'd7
`define ALU_SLT     4'd8
`define ALU_SLTU    4'd9
`define ALU_SEQ     4'd10
`define ALU_SNE     4'd11

// writeback result select
`define RSEL_W      2
`define RSEL_ALU    2'd0
`define RSEL_PCIMM  2'd1
`define RSEL_PCPLUS 2'd2
`define RSEL_IMM    2'd3

`define WORD_ZERO   32'h0000_0000

`endif

// ==== exu_pkg.sv ====
// packet types exchanged by the execute stage, its neighbours and the testbench
`include "exu_params.svh"

package exu_pkg;

    // one decoded instruction as handed over by decode
    typedef struct packed {
        logic                 valid;
        logic [`XLEN-1:0]     pc;
        logic [`XLEN-1:0]     pc_plus;
        logic [`REG_AW-1:0]   rs1;
        logic [`REG_AW-1:0]   rs2;
        logic [`REG_AW-1:0]   rd;
        logic [`XLEN-1:0]     rd1;
        logic [`XLEN-1:0]     rd2;
        logic [`XLEN-1:0]     imm;
        logic [`ALU_OP_W-1:0] alu_op;
        // second alu operand comes from imm
        logic                 op2_imm;
        logic [`RSEL_W-1:0]   res_sel;
        logic                 rf_we;
        logic                 mem_we;
        logic                 mem_re;
        logic [2:0]           mem_byte_sel;
        logic                 branch;
        // set for both jal and jalr
        logic                 jal_jalr;
        logic                 jalr;
        // decode-time prediction
        logic                 bp_taken;
        logic [`XLEN-1:0]     bp_pc;
    } issue_pkt_t;

    // register write port of a later stage, used for forwarding
    typedef struct packed {
        logic               we;
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   data;
    } fwd_port_t;

    // request to the memory stage
    typedef struct packed {
        logic               valid;
        logic [`XLEN-1:0]   pc;
        logic [`REG_AW-1:0] rd;
        logic               rf_we;
        logic               mem_we;
        logic               mem_re;
        logic [2:0]         mem_byte_sel;
        logic [`XLEN-1:0]   dout;
        logic [`XLEN-1:0]   store_data;
    } lsu_req_t;

    // fetch redirect on a mispredicted control transfer
    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
    } redirect_t;

endpackage

// ==== exu_stage_reg.sv ====
// issue register between decode and execute, holds its packet while the pipeline is stalled
`timescale 1ns/1ps

module exu_stage_reg (
    input  logic                clk,
    input  logic                rstn,
    input  logic                stall,
    input  exu_pkg::issue_pkt_t issue,
    output exu_pkg::issue_pkt_t cur
);

    // whole packet cleared on reset, so valid and enables start low
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cur <= '0;
        end else if (!stall) begin
            cur <= issue;
        end
    end

endmodule

// ==== operand_forward.sv ====
// source operand select with bypass from the memory and writeback stages
`timescale 1ns/1ps
`include "exu_params.svh"

module operand_forward (
    input  logic [`REG_AW-1:0] rs1,
    input  logic [`REG_AW-1:0] rs2,
    input  logic [`XLEN-1:0]   rf_rd1,
    input  logic [`XLEN-1:0]   rf_rd2,
    input  exu_pkg::fwd_port_t lsu_fwd,
    input  exu_pkg::fwd_port_t wb_fwd,
    output logic [`XLEN-1:0]   op_a,
    output logic [`XLEN-1:0]   op_b
);

    // true when a write port produces the value this source reads
    function automatic logic hits(input exu_pkg::fwd_port_t port,
                                  input logic [`REG_AW-1:0] src);
        return port.we && (port.rd != '0) && (port.rd == src);
    endfunction

    // youngest producer first, x0 is never bypassed
    function automatic logic [`XLEN-1:0] pick(input logic [`REG_AW-1:0] src,
                                               input logic [`XLEN-1:0]   rf_val,
                                               input exu_pkg::fwd_port_t lsu,
                                               input exu_pkg::fwd_port_t wb);
        logic [`XLEN-1:0] val;
        if (hits(lsu, src)) begin
            val = lsu.data;
        end else if (hits(wb, src)) begin
            val = wb.data;
        end else begin
            val = rf_val;
        end
        return val;
    endfunction

    assign op_a = pick(rs1, rf_rd1, lsu_fwd, wb_fwd);
    assign op_b = pick(rs2, rf_rd2, lsu_fwd, wb_fwd);

endmodule

// ==== exu_alu.sv ====
// integer ALU with pc plus immediate adder and the writeback result select
`timescale 1ns/1ps
`include "exu_params.svh"

module exu_alu (
    input  exu_pkg::issue_pkt_t cur,
    input  logic [`XLEN-1:0]    op_a,
    input  logic [`XLEN-1:0]    op_b,
    output logic [`XLEN-1:0]    alu_out,
    output logic [`XLEN-1:0]    dout,
    output logic                cmp,
    output logic [`XLEN-1:0]    pc_imm
);

    logic [`XLEN-1:0] op2;
    logic [4:0]       shamt;
    logic             lt_s;
    logic             lt_u;
    logic             eq;

    assign op2   = cur.op2_imm ? cur.imm : op_b;
    assign shamt = op2[4:0];
    assign lt_s  = $signed(op_a) < $signed(op2);
    assign lt_u  = op_a < op2;
    assign eq    = op_a == op2;

    always_comb begin
        alu_out = `WORD_ZERO;
        cmp     = 1'b0;
        case (cur.alu_op)
            `ALU_ADD:  alu_out = op_a + op2;
            `ALU_SUB:  alu_out = op_a - op2;
            `ALU_AND:  alu_out = op_a & op2;
            `ALU_OR:   alu_out = op_a | op2;
            `ALU_XOR:  alu_out = op_a ^ op2;
            `ALU_SLL:  alu_out = op_a << shamt;
            `ALU_SRL:  alu_out = op_a >> shamt;
            `ALU_SRA:  alu_out = $unsigned($signed(op_a) >>> shamt);
            // compares give a 0/1 word and drive the branch bit
            `ALU_SLT: begin
                cmp     = lt_s;
                alu_out = {{(`XLEN-1){1'b0}}, lt_s};
            end
            `ALU_SLTU: begin
                cmp     = lt_u;
                alu_out = {{(`XLEN-1){1'b0}}, lt_u};
            end
            `ALU_SEQ: begin
                cmp     = eq;
                alu_out = {{(`XLEN-1){1'b0}}, eq};
            end
            `ALU_SNE: begin
                cmp     = ~eq;
                alu_out = {{(`XLEN-1){1'b0}}, ~eq};
            end
            default:   alu_out = `WORD_ZERO;
        endcase
    end

    // branch and jal target, also auipc result
    assign pc_imm = cur.pc + cur.imm;

    always_comb begin
        case (cur.res_sel)
            `RSEL_ALU:    dout = alu_out;
            `RSEL_PCIMM:  dout = pc_imm;
            `RSEL_PCPLUS: dout = cur.pc_plus;
            `RSEL_IMM:    dout = cur.imm;
            default:      dout = alu_out;
        endcase
    end

endmodule

// ==== branch_resolve.sv ====
// checks branches and jumps against the decode prediction and forms the fetch redirect
`timescale 1ns/1ps
`include "exu_params.svh"

module branch_resolve (
    input  exu_pkg::issue_pkt_t cur,
    input  logic                cmp,
    input  logic [`XLEN-1:0]    alu_out,
    input  logic [`XLEN-1:0]    pc_imm,
    output exu_pkg::redirect_t  redirect
);

    logic [`XLEN-1:0] jalr_pc;
    logic             br_miss;
    logic             jal_miss;
    logic             jalr_miss;

    // jalr target is rs1 + imm with bit 0 dropped
    assign jalr_pc = {alu_out[`XLEN-1:1], 1'b0};

    // conditional branch resolved the other way than predicted
    assign br_miss = cur.branch && (cmp != cur.bp_taken);

    // jal always jumps, wrong only if fetch fell through
    assign jal_miss = cur.jal_jalr && !cur.jalr && !cur.bp_taken;

    // jalr needs both direction and predicted address right
    assign jalr_miss = cur.jalr && (!cur.bp_taken || (cur.bp_pc != jalr_pc));

    assign redirect.valid = cur.valid && (br_miss || jal_miss || jalr_miss);

    // predicted-taken branch that falls through resumes at pc + 4
    assign redirect.pc = cur.jalr     ? jalr_pc :
                         cur.bp_taken ? cur.pc_plus :
                                        pc_imm;

endmodule

// ==== exu_top.sv ====
// execute stage top, joins issue register, forwarding, ALU and branch check, applies flush
`timescale 1ns/1ps
`include "exu_params.svh"

module exu_top (
    input  logic                clk,
    input  logic                rstn,
    input  logic                stall,
    input  logic                flush,
    input  exu_pkg::issue_pkt_t issue,
    input  exu_pkg::fwd_port_t  lsu_fwd,
    input  exu_pkg::fwd_port_t  wb_fwd,
    output exu_pkg::lsu_req_t   lsu_req,
    output exu_pkg::redirect_t  redirect
);

    exu_pkg::issue_pkt_t cur;
    exu_pkg::redirect_t  redirect_raw;
    logic [`XLEN-1:0]    op_a;
    logic [`XLEN-1:0]    op_b;
    logic [`XLEN-1:0]    alu_out;
    logic [`XLEN-1:0]    dout;
    logic [`XLEN-1:0]    pc_imm;
    logic                cmp;

    exu_stage_reg i_exu_stage_reg (
        .clk   (clk),
        .rstn  (rstn),
        .stall (stall),
        .issue (issue),
        .cur   (cur)
    );

    operand_forward i_operand_forward (
        .rs1     (cur.rs1),
        .rs2     (cur.rs2),
        .rf_rd1  (cur.rd1),
        .rf_rd2  (cur.rd2),
        .lsu_fwd (lsu_fwd),
        .wb_fwd  (wb_fwd),
        .op_a    (op_a),
        .op_b    (op_b)
    );

    exu_alu i_exu_alu (
        .cur     (cur),
        .op_a    (op_a),
        .op_b    (op_b),
        .alu_out (alu_out),
        .dout    (dout),
        .cmp     (cmp),
        .pc_imm  (pc_imm)
    );

    branch_resolve i_branch_resolve (
        .cur      (cur),
        .cmp      (cmp),
        .alu_out  (alu_out),
        .pc_imm   (pc_imm),
        .redirect (redirect_raw)
    );

    // flush kills the stage, payload passes through untouched
    assign lsu_req.valid        = cur.valid && !flush;
    assign lsu_req.pc           = cur.pc;
    assign lsu_req.rd           = cur.rd;
    assign lsu_req.rf_we        = cur.rf_we && !flush;
    assign lsu_req.mem_we       = cur.mem_we && !flush;
    assign lsu_req.mem_re       = cur.mem_re && !flush;
    assign lsu_req.mem_byte_sel = cur.mem_byte_sel;
    assign lsu_req.dout         = dout;
    // store data sees the same bypass as rs2
    assign lsu_req.store_data   = op_b;

    assign redirect.valid = redirect_raw.valid && !flush;
    assign redirect.pc    = redirect_raw.pc;

endmodule

// ==== exu_properties.sv ====
// concurrent checks on the execute stage outputs, bound into exu_top by the testbench
`timescale 1ns/1ps

module exu_properties (
    input logic                clk,
    input logic                rstn,
    input logic                stall,
    input logic                flush,
    input exu_pkg::issue_pkt_t cur,
    input exu_pkg::lsu_req_t   lsu_req,
    input exu_pkg::redirect_t  redirect
);

    logic        quiet;
    int unsigned fail_count = 0;

    // nothing leaves the stage as active
    assign quiet = !lsu_req.valid && !lsu_req.rf_we && !lsu_req.mem_we &&
                   !lsu_req.mem_re && !redirect.valid;

    reset_quiet: assert property (@(posedge clk) !rstn |-> quiet)
        else begin
            fail_count++;
            $error("outputs active during reset");
        end

    flush_quiet: assert property (@(posedge clk) disable iff (!rstn) flush |-> quiet)
        else begin
            fail_count++;
            $error("outputs active while flush is high");
        end

    // held packet with steady bypass ports, so the request repeats
    stall_hold: assert property (@(posedge clk) disable iff (!rstn)
        $past(stall) && $past(rstn) && !flush && !$past(flush) |-> lsu_req == $past(lsu_req))
        else begin
            fail_count++;
            $error("lsu request changed during a stall");
        end

    redirect_needs_valid: assert property (@(posedge clk) disable iff (!rstn)
        !cur.valid |-> !redirect.valid)
        else begin
            fail_count++;
            $error("redirect raised for an invalid packet");
        end

endmodule

// ==== tb_exu.sv ====
// testbench driving directed and random packets into the execute stage and checking a model
`timescale 1ns/1ps
`include "exu_params.svh"

module tb_exu;

    localparam int N_ALU = 40;
    // reset, two cycles per packet, extra stall and flush cycles
    localparam int TEST_CYCLES = 3 + 2 * N_ALU + 8 + 6 + 4 + 10 + 10;
    localparam int MAX_CYCLES = 2 * TEST_CYCLES;

    logic                clk;
    logic                rstn;
    logic                stall;
    logic                flush;
    exu_pkg::issue_pkt_t issue;
    exu_pkg::fwd_port_t  lsu_fwd;
    exu_pkg::fwd_port_t  wb_fwd;
    exu_pkg::lsu_req_t   lsu_req;
    exu_pkg::redirect_t  redirect;
    exu_pkg::issue_pkt_t p;
    exu_pkg::fwd_port_t  lf;
    exu_pkg::fwd_port_t  wf;
    string               test_name;
    int                  errs = 0;
    int                  checks = 0;
    int                  total_errs = 0;
    int                  total_checks = 0;
    int                  tests = 0;
    int                  cycles = 0;

    exu_top i_exu_top (.*);
    bind exu_top exu_properties i_exu_properties (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cycles <= cycles + 1;

    initial begin
        wait (cycles > MAX_CYCLES);
        $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    // memory stage first, then writeback, never x0
    function automatic logic [`XLEN-1:0] fwd_ref(input logic [`REG_AW-1:0] src,
                                                 input logic [`XLEN-1:0]   rf_val);
        if (src != '0 && lsu_fwd.we && lsu_fwd.rd == src) return lsu_fwd.data;
        if (src != '0 && wb_fwd.we && wb_fwd.rd == src) return wb_fwd.data;
        return rf_val;
    endfunction

    function automatic void model(input exu_pkg::issue_pkt_t q, input logic [`XLEN-1:0] a,
                                  input logic [`XLEN-1:0] b, output logic [`XLEN-1:0] d,
                                  output exu_pkg::redirect_t r);
        logic [`XLEN-1:0] y;
        logic [`XLEN-1:0] res;
        logic [`XLEN-1:0] tgt;
        logic             c;
        y   = q.op2_imm ? q.imm : b;
        c   = 1'b0;
        res = '0;
        case (q.alu_op)
            `ALU_ADD:  res = a + y;
            `ALU_SUB:  res = a - y;
            `ALU_AND:  res = a & y;
            `ALU_OR:   res = a | y;
            `ALU_XOR:  res = a ^ y;
            `ALU_SLL:  res = a << y[4:0];
            `ALU_SRL:  res = a >> y[4:0];
            `ALU_SRA:  res = $signed(a) >>> y[4:0];
            `ALU_SLT:  c = $signed(a) < $signed(y);
            `ALU_SLTU: c = a < y;
            `ALU_SEQ:  c = a == y;
            `ALU_SNE:  c = a != y;
            default:   res = '0;
        endcase
        // compare ops return the compare bit as a word
        if (q.alu_op >= `ALU_SLT) res = `XLEN'(c);
        case (q.res_sel)
            `RSEL_ALU:    d = res;
            `RSEL_PCIMM:  d = q.pc + q.imm;
            `RSEL_PCPLUS: d = q.pc_plus;
            default:      d = q.imm;
        endcase
        tgt     = res & ~`XLEN'(1);
        r.valid = q.valid && ((q.branch && c != q.bp_taken) ||
                  (q.jal_jalr && !q.jalr && !q.bp_taken) ||
                  (q.jalr && (!q.bp_taken || q.bp_pc != tgt)));
        r.pc    = q.jalr ? tgt : (q.bp_taken ? q.pc_plus : q.pc + q.imm);
    endfunction

    task automatic check_word(input string what, input logic [`XLEN-1:0] exp,
                              input logic [`XLEN-1:0] act);
        checks++;
        assert (act === exp) else begin
            $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
            errs++;
        end
    endtask

    // output cycle of packet q, with the bypass ports and flush as driven now
    task automatic compare_outputs(input exu_pkg::issue_pkt_t q);
        logic [`XLEN-1:0]   a;
        logic [`XLEN-1:0]   b;
        logic [`XLEN-1:0]   d;
        exu_pkg::redirect_t r;
        a = fwd_ref(q.rs1, q.rd1);
        b = fwd_ref(q.rs2, q.rd2);
        model(q, a, b, d, r);
        check_word("valid", `XLEN'(q.valid && !flush), `XLEN'(lsu_req.valid));
        check_word("enables", `XLEN'({q.rf_we, q.mem_we, q.mem_re} & {3{!flush}}),
                   `XLEN'({lsu_req.rf_we, lsu_req.mem_we, lsu_req.mem_re}));
        check_word("pc", q.pc, lsu_req.pc);
        check_word("rd and byte select", `XLEN'({q.rd, q.mem_byte_sel}),
                   `XLEN'({lsu_req.rd, lsu_req.mem_byte_sel}));
        check_word("dout", d, lsu_req.dout);
        check_word("store_data", b, lsu_req.store_data);
        check_word("redirect valid", `XLEN'(r.valid && !flush), `XLEN'(redirect.valid));
        check_word("redirect pc", r.pc, redirect.pc);
    endtask

    task automatic send(input exu_pkg::issue_pkt_t q, input exu_pkg::fwd_port_t lsu_in,
                        input exu_pkg::fwd_port_t wb_in);
        @(posedge clk);
        #10;
        issue   = q;
        lsu_fwd = lsu_in;
        wb_fwd  = wb_in;
        @(posedge clk);
        @(negedge clk);
        compare_outputs(q);
    endtask

    task automatic end_test();
        $display("%s: %0d checks, %0d failed", test_name, checks, errs);
        total_errs   += errs;
        total_checks += checks;
        tests++;
        errs   = 0;
        checks = 0;
    endtask

    initial begin
        void'($urandom(32'he6bf));
        rstn    = 1'b0;
        stall   = 1'b0;
        flush   = 1'b0;
        issue   = '0;
        lsu_fwd = '0;
        wb_fwd  = '0;
        repeat (3) @(posedge clk);
        #10;
        rstn = 1'b1;

        // random ops over every result select, random bypass ports
        test_name = "alu";
        for (int i = 0; i < N_ALU; i++) begin
            p              = '0;
            p.valid        = ($urandom_range(7, 0) != 0);
            p.pc           = $urandom & 32'hffff_fffc;
            p.pc_plus      = p.pc + 32'd4;
            p.rs1          = `REG_AW'($urandom_range(3, 0));
            p.rs2          = `REG_AW'($urandom_range(3, 0));
            p.rd           = `REG_AW'($urandom);
            p.rd1          = $urandom;
            p.rd2          = $urandom;
            p.imm          = $urandom;
            p.alu_op       = `ALU_OP_W'($urandom_range(11, 0));
            p.op2_imm      = 1'($urandom);
            p.res_sel      = 2'(i);
            p.rf_we        = 1'($urandom);
            p.mem_we       = 1'($urandom);
            p.mem_re       = 1'($urandom);
            p.mem_byte_sel = 3'($urandom);
            lf             = {1'($urandom), `REG_AW'($urandom_range(3, 0)), $urandom};
            wf             = {1'($urandom), `REG_AW'($urandom_range(3, 0)), $urandom};
            send(p, lf, wf);
        end
        end_test();

        test_name = "forward";
        p         = '0;
        p.valid   = 1'b1;
        p.rd1     = 32'h0000_a000;
        p.rd2     = 32'h0000_0b00;
        p.rs1     = 5'd5;
        p.rs2     = 5'd5;
        send(p, {1'b1, 5'd5, 32'h1111_0000}, {1'b1, 5'd5, 32'h2222_0000});
        p.rs2     = 5'd6;
        send(p, {1'b0, 5'd5, 32'h1111_0000}, {1'b1, 5'd6, 32'h2222_0000});
        p.rs1     = 5'd0;
        p.rs2     = 5'd0;
        send(p, {1'b1, 5'd0, 32'h1111_0000}, {1'b1, 5'd0, 32'h2222_0000});
        p.rs1     = 5'd7;
        p.rs2     = 5'd7;
        send(p, {1'b1, 5'd8, 32'h1111_0000}, {1'b1, 5'd7, 32'h2222_0000});
        end_test();

        // a new packet waits behind the stall
        test_name = "stall";
        lf        = '0;
        wf        = '0;
        send(p, lf, wf);
        @(posedge clk);
        #10;
        stall     = 1'b1;
        issue.rd1 = 32'h0000_0777;
        @(negedge clk);
        compare_outputs(p);
        @(posedge clk);
        @(negedge clk);
        compare_outputs(p);
        @(posedge clk);
        #10;
        stall = 1'b0;
        @(negedge clk);
        compare_outputs(p);
        @(posedge clk);
        @(negedge clk);
        compare_outputs(issue);
        end_test();

        // mispredicted branch with all enables set, then killed
        test_name = "flush";
        p.rf_we   = 1'b1;
        p.mem_we  = 1'b1;
        p.mem_re  = 1'b1;
        p.branch  = 1'b1;
        p.alu_op  = `ALU_SNE;
        send(p, lf, wf);
        @(posedge clk);
        #10;
        flush = 1'b1;
        @(negedge clk);
        compare_outputs(p);
        @(posedge clk);
        #10;
        flush = 1'b0;
        end_test();

        // compare result against prediction, last case on an invalid packet
        test_name = "branch";
        p         = '0;
        p.pc      = 32'h0000_1000;
        p.pc_plus = 32'h0000_1004;
        p.imm     = 32'h0000_0040;
        p.rd1     = 32'd7;
        p.branch  = 1'b1;
        p.alu_op  = `ALU_SEQ;
        for (int k = 0; k < 5; k++) begin
            p.rd2      = k[0] ? 32'd7 : 32'd9;
            p.bp_taken = k[1] | k[2];
            p.valid    = (k < 4);
            send(p, lf, wf);
        end
        end_test();

        // jal unpredicted and predicted, jalr unpredicted, wrong target, right target
        test_name  = "jump";
        p          = '0;
        p.valid    = 1'b1;
        p.pc       = 32'h0000_2000;
        p.pc_plus  = 32'h0000_2004;
        p.imm      = 32'h0000_0100;
        p.rd1      = 32'h0000_4001;
        p.op2_imm  = 1'b1;
        p.res_sel  = `RSEL_PCPLUS;
        p.rf_we    = 1'b1;
        p.jal_jalr = 1'b1;
        for (int k = 0; k < 5; k++) begin
            p.jalr     = (k >= 2);
            p.bp_taken = (k == 1) || (k >= 3);
            p.bp_pc    = (k == 4) ? 32'h0000_4100 : 32'h0000_5000;
            send(p, lf, wf);
        end
        end_test();

        total_errs += i_exu_top.i_exu_properties.fail_count;
        $display("%0d tests, %0d checks, %0d failed", tests, total_checks, total_errs);
        if (total_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+.
exu_pkg.sv
exu_stage_reg.sv
operand_forward.sv
exu_alu.sv
branch_resolve.sv
exu_top.sv
exu_properties.sv
tb_exu.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --assert --timescale 1ns/1ps -j 0
TOP       = tb_exu
FILELIST  = all.f
SIM       = obj_dir/V$(TOP)
SOURCES   = $(filter-out +%,$(shell cat $(FILELIST))) exu_params.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'RESULT: PASS'

clean:
	rm -rf obj_dir
